//--- counter_pkg.sv
// shared definitions for the tag counter
//  stream field widths and the ignored-lane sentinel
//  wishbone widths and register word map
//  default window length
//  control FSM state encoding
`default_nettype none

package counter_pkg;

    //////////////////////////////
    // tag stream
    localparam int CHAN_W = 6;                         // 64 detector channels
    localparam int LANE_W = 6;                         // lane index width
    localparam logic [LANE_W-1:0] LANE_NONE = '1;      // channel not counted

    //////////////////////////////
    // wishbone and register map
    localparam int WB_ADR_W = 8;                       // word addresses
    localparam int WB_DAT_W = 32;

    localparam logic [WB_ADR_W-1:0] ADDR_CTRL       = 8'h00; // b0 start, b1 stop
    localparam logic [WB_ADR_W-1:0] ADDR_STATUS     = 8'h01; // b0 running, b1 snapshot held
    localparam logic [WB_ADR_W-1:0] ADDR_WINDOW     = 8'h02; // window length in cycles
    localparam logic [WB_ADR_W-1:0] ADDR_COUNT_BASE = 8'h10; // + lane
    localparam logic [WB_ADR_W-1:0] ADDR_LUT_BASE   = 8'h40; // + channel

    localparam logic [WB_DAT_W-1:0] DEFAULT_WINDOW = 32'd1000;

    // control FSM
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        COUNT    = 2'd1,
        STOPPING = 2'd2                                // finish current window then idle
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- counter_cfg_if.sv
// configuration and control bundle
//  window length, start and stop pulses, lookup-table write port
//  running flag back from the control FSM
//  modports for register block, FSM, channel map and timer
`timescale 1ns/1ps
`default_nettype none

interface counter_cfg_if;

    logic [counter_pkg::WB_DAT_W-1:0] window_len;   // cycles per window
    logic                             start_req;    // single-cycle pulse
    logic                             stop_req;     // single-cycle pulse
    logic                             lut_we;       // table write strobe
    logic [counter_pkg::CHAN_W-1:0]   lut_addr;     // channel being written
    logic [counter_pkg::LANE_W-1:0]   lut_lane;     // lane for that channel
    logic                             running;      // FSM out of idle

    // register block drives everything except running
    modport regs (
        output window_len, start_req, stop_req, lut_we, lut_addr, lut_lane,
        input  running
    );

    modport ctrl (input start_req, stop_req, output running);

    modport map (input lut_we, lut_addr, lut_lane);

    modport timer (input window_len);

endinterface

`default_nettype wire

//--- channel_map.sv
// channel to lane lookup
//  64-entry table written through the config interface
//  registered lookup stage producing lane hits
//  ignored and out-of-range entries give no hit
`timescale 1ns/1ps
`default_nettype none

module channel_map #(
    parameter int NUM_LANES = 4
) (
    input  wire                            detector,
    input  wire                            arst_n_i,
    input  wire                            tag_valid_i,
    input  wire  [counter_pkg::CHAN_W-1:0] tag_channel_i,
    counter_cfg_if.map                     cfg,
    output logic                           hit_valid_o,
    output logic [counter_pkg::LANE_W-1:0] hit_lane_o
);

    localparam int DEPTH  = 2 ** counter_pkg::CHAN_W;
    localparam int LIMIT_W = counter_pkg::LANE_W + 1;  // room for NUM_LANES itself
    localparam logic [LIMIT_W-1:0] LANE_LIMIT = LIMIT_W'(NUM_LANES);

    logic [counter_pkg::LANE_W-1:0] lut [DEPTH];
    logic [counter_pkg::LANE_W-1:0] entry;
    logic                           entry_ok;

    assign entry    = lut[tag_channel_i];              // read for the current tag
    assign entry_ok = (entry != counter_pkg::LANE_NONE) &&
                      ({1'b0, entry} < LANE_LIMIT);    // lane must exist

    // table starts with every channel ignored
    always_ff @(posedge detector or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < DEPTH; i++) begin
                lut[i] <= counter_pkg::LANE_NONE;
            end
        end else if (cfg.lut_we) begin
            lut[cfg.lut_addr] <= cfg.lut_lane;
        end
    end

    //////////////////////////////
    // lookup stage, tag at t shows as hit at t+1
    always_ff @(posedge detector or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hit_valid_o <= 1'b0;
        end else begin
            hit_valid_o <= tag_valid_i && entry_ok;
        end
    end

    always_ff @(posedge detector) begin
        hit_lane_o <= entry;                           // only meaningful with hit_valid_o
    end

endmodule

`default_nettype wire

//--- window_timer.sv
// window length timer
//  down-counter loaded from the window register
//  reloads on expiry so windows run back to back
//  window_end marks the last cycle of each window
`timescale 1ns/1ps
`default_nettype none

module window_timer (
    input  wire           detector,
    input  wire           arst_n_i,
    input  wire           load_i,
    input  wire           run_i,
    counter_cfg_if.timer  cfg,
    output logic          window_end_o
);

    logic [counter_pkg::WB_DAT_W-1:0] remain;          // cycles left in window minus one

    // last cycle of the window
    assign window_end_o = run_i && (remain == '0);

    always_ff @(posedge detector or negedge arst_n_i) begin
        if (!arst_n_i) begin
            remain <= '0;
        end else if (load_i || window_end_o) begin
            remain <= cfg.window_len - 1'b1;           // first end comes window_len cycles on
        end else if (run_i) begin
            remain <= remain - 1'b1;
        end
    end

    // a window is at least two cycles long
    a_end_single: assert property (
        @(posedge detector) disable iff (!arst_n_i)
        window_end_o |=> !window_end_o
    ) else $error("window_end held high for two cycles");

endmodule

`default_nettype wire

//--- counter_ctrl.sv
// counting control FSM
//  idle, counting and stopping states
//  start loads the timer and clears the lanes
//  stop lets the current window finish before idling
`timescale 1ns/1ps
`default_nettype none

module counter_ctrl (
    input  wire           detector,
    input  wire           arst_n_i,
    counter_cfg_if.ctrl   cfg,
    input  wire           window_end_i,
    output logic          timer_load_o,
    output logic          timer_run_o,
    output logic          count_en_o,
    output logic          clear_o
);

    counter_pkg::ctrl_state_t state_q;
    counter_pkg::ctrl_state_t state_d;
    logic                     active;

    always_comb begin
        state_d = state_q;
        case (state_q)
            counter_pkg::IDLE: begin
                if (cfg.start_req) begin
                    state_d = counter_pkg::COUNT;
                end
            end
            counter_pkg::COUNT: begin
                if (cfg.stop_req) begin               // window ending now needs no extra one
                    state_d = window_end_i ? counter_pkg::IDLE : counter_pkg::STOPPING;
                end
            end
            counter_pkg::STOPPING: begin
                if (window_end_i) begin
                    state_d = counter_pkg::IDLE;      // last snapshot taken this cycle
                end
            end
            default: state_d = counter_pkg::IDLE;
        endcase
    end

    always_ff @(posedge detector or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= counter_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign active       = (state_q != counter_pkg::IDLE);
    assign timer_load_o = (state_q == counter_pkg::IDLE) && cfg.start_req;
    assign clear_o      = (state_q == counter_pkg::IDLE) && cfg.start_req; // fresh counts
    assign timer_run_o  = active;
    assign count_en_o   = active;
    assign cfg.running  = active;

    // a lane clear comes with a timer load and never lands on a window end
    // since the clear would drop that window's snapshot
    a_clear_load: assert property (
        @(posedge detector) disable iff (!arst_n_i)
        clear_o |-> (timer_load_o && !window_end_i)
    ) else $error("lane clear without timer load or on a window end");

endmodule

`default_nettype wire

//--- lane_counters.sv
// per-lane hit accumulators
//  saturating counters, one per lane
//  snapshot on window end with same-cycle hit included
//  snapshot valid pulse one cycle after window end
`timescale 1ns/1ps
`default_nettype none

module lane_counters #(
    parameter int NUM_LANES = 4,
    parameter int COUNT_W   = 32
) (
    input  wire                            detector,
    input  wire                            arst_n_i,
    input  wire                            hit_valid_i,
    input  wire  [counter_pkg::LANE_W-1:0] hit_lane_i,
    input  wire                            count_en_i,
    input  wire                            clear_i,
    input  wire                            window_end_i,
    output logic [COUNT_W-1:0]             snap_o [NUM_LANES],
    output logic                           snap_valid_o
);

    logic [COUNT_W-1:0] acc [NUM_LANES];               // running window counts

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        localparam logic [counter_pkg::LANE_W-1:0] LANE_ID = l;

        logic               inc;
        logic [COUNT_W-1:0] acc_next;

        assign inc      = count_en_i && hit_valid_i && (hit_lane_i == LANE_ID);
        assign acc_next = (inc && (acc[l] != '1)) ? acc[l] + 1'b1 : acc[l]; // hold at max

        always_ff @(posedge detector or negedge arst_n_i) begin
            if (!arst_n_i) begin
                acc[l]    <= '0;
                snap_o[l] <= '0;
            end else if (clear_i) begin
                acc[l]    <= '0;                       // start of a run
            end else if (window_end_i) begin
                snap_o[l] <= acc_next;                 // includes hit on the boundary
                acc[l]    <= '0;                       // next window starts empty
            end else begin
                acc[l]    <= acc_next;
            end
        end
    end

    //////////////////////////////
    // valid pulse lines up with the new snapshot
    always_ff @(posedge detector or negedge arst_n_i) begin
        if (!arst_n_i) begin
            snap_valid_o <= 1'b0;
        end else begin
            snap_valid_o <= window_end_i;
        end
    end

    // channel map filters out lanes that do not exist
    a_lane_range: assert property (
        @(posedge detector) disable iff (!arst_n_i)
        hit_valid_i |-> (int'(hit_lane_i) < NUM_LANES)
    ) else $error("hit on lane %0d beyond NUM_LANES", hit_lane_i);

endmodule

`default_nettype wire

//--- counter_wb_regs.sv
// wishbone classic register block
//  window length register and start/stop pulses
//  lookup-table writes with a readback copy
//  status and snapshot count reads
`timescale 1ns/1ps
`default_nettype none

module counter_wb_regs #(
    parameter int NUM_LANES = 4,
    parameter int COUNT_W   = 32
) (
    input  wire                              detector,
    input  wire                              arst_n_i,
    input  wire                              wb_cyc_i,
    input  wire                              wb_stb_i,
    input  wire                              wb_we_i,
    input  wire  [counter_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  wire  [counter_pkg::WB_DAT_W-1:0] wb_dat_i,
    output logic [counter_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                             wb_ack_o,
    counter_cfg_if.regs                      cfg,
    input  wire  [COUNT_W-1:0]               snap_i [NUM_LANES]
);

    localparam int LUT_N = 2 ** counter_pkg::CHAN_W;
    localparam int ADR_W = counter_pkg::WB_ADR_W;
    localparam int DAT_W = counter_pkg::WB_DAT_W;
    localparam int IDX_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;
    localparam logic [ADR_W-1:0] LANES_A = ADR_W'(NUM_LANES);

    logic [DAT_W-1:0]                 window_q;
    logic [counter_pkg::LANE_W-1:0]   lut_copy [LUT_N];   // mirror of channel_map table
    logic [ADR_W-1:0]                 cnt_idx;
    logic                             is_lut;
    logic                             is_count;
    logic                             wr_fire;
    logic                             running_q;
    logic                             snap_seen_q;

    //////////////////////////////
    // bus handshake
    always_ff @(posedge detector or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o; // one cycle per request
        end
    end

    assign wr_fire  = wb_ack_o && wb_we_i;             // writes land on the ack cycle
    assign cnt_idx  = wb_adr_i - counter_pkg::ADDR_COUNT_BASE;
    assign is_count = (wb_adr_i >= counter_pkg::ADDR_COUNT_BASE) && (cnt_idx < LANES_A);
    assign is_lut   = (wb_adr_i[ADR_W-1:counter_pkg::CHAN_W] ==
                       counter_pkg::ADDR_LUT_BASE[ADR_W-1:counter_pkg::CHAN_W]);

    // config outputs
    assign cfg.window_len = window_q;
    assign cfg.start_req  = wr_fire && (wb_adr_i == counter_pkg::ADDR_CTRL) && wb_dat_i[0];
    assign cfg.stop_req   = wr_fire && (wb_adr_i == counter_pkg::ADDR_CTRL) && wb_dat_i[1];
    assign cfg.lut_we     = wr_fire && is_lut;
    assign cfg.lut_addr   = wb_adr_i[counter_pkg::CHAN_W-1:0];
    assign cfg.lut_lane   = wb_dat_i[counter_pkg::LANE_W-1:0];

    always_ff @(posedge detector or negedge arst_n_i) begin
        if (!arst_n_i) begin
            window_q    <= counter_pkg::DEFAULT_WINDOW;
            running_q   <= 1'b0;
            snap_seen_q <= 1'b0;
            for (int i = 0; i < LUT_N; i++) begin
                lut_copy[i] <= counter_pkg::LANE_NONE;
            end
        end else begin
            if (wr_fire && (wb_adr_i == counter_pkg::ADDR_WINDOW)) begin
                window_q <= wb_dat_i;
            end
            if (cfg.lut_we) begin
                lut_copy[cfg.lut_addr] <= cfg.lut_lane;
            end
            running_q <= cfg.running;
            // a finished run always leaves its last window in the snapshot
            if (running_q && !cfg.running) begin
                snap_seen_q <= 1'b1;
            end
        end
    end

    //////////////////////////////
    // read mux, valid while ack is high
    always_comb begin
        wb_dat_o = '0;
        if (is_lut) begin
            wb_dat_o[counter_pkg::LANE_W-1:0] = lut_copy[wb_adr_i[counter_pkg::CHAN_W-1:0]];
        end else if (is_count) begin
            wb_dat_o = DAT_W'(snap_i[cnt_idx[IDX_W-1:0]]);
        end else if (wb_adr_i == counter_pkg::ADDR_STATUS) begin
            wb_dat_o[1:0] = {snap_seen_q, cfg.running};
        end else if (wb_adr_i == counter_pkg::ADDR_WINDOW) begin
            wb_dat_o = window_q;
        end
    end

    // master holds its request until ack
    a_ack_req: assert property (
        @(posedge detector) disable iff (!arst_n_i)
        wb_ack_o |-> (wb_cyc_i && wb_stb_i && $past(wb_cyc_i && wb_stb_i))
    ) else $error("ack without a held cyc and stb");

endmodule

`default_nettype wire

//--- tag_counter_top.sv
// windowed tag counter top level
//  config interface, channel map, window timer
//  control FSM, lane counters, wishbone registers
//  flattened count output bus
`timescale 1ns/1ps
`default_nettype none

module tag_counter_top #(
    parameter int NUM_LANES = 4,
    parameter int COUNT_W   = 32
) (
    input  wire                              detector,
    input  wire                              arst_n_i,
    input  wire                              tag_valid_i,
    input  wire  [counter_pkg::CHAN_W-1:0]   tag_channel_i,
    input  wire                              wb_cyc_i,
    input  wire                              wb_stb_i,
    input  wire                              wb_we_i,
    input  wire  [counter_pkg::WB_ADR_W-1:0] wb_adr_i,
    input  wire  [counter_pkg::WB_DAT_W-1:0] wb_dat_i,
    output logic [counter_pkg::WB_DAT_W-1:0] wb_dat_o,
    output logic                             wb_ack_o,
    output logic [NUM_LANES*COUNT_W-1:0]     count_data_o,
    output logic                             count_valid_o
);

    counter_cfg_if cfg ();

    logic                           hit_valid;
    logic [counter_pkg::LANE_W-1:0] hit_lane;
    logic                           timer_load;
    logic                           timer_run;
    logic                           window_end;
    logic                           count_en;
    logic                           clear;
    logic [COUNT_W-1:0]             snap [NUM_LANES];

    channel_map #(.NUM_LANES(NUM_LANES)) u_map (
        .detector, .arst_n_i, .tag_valid_i, .tag_channel_i, .cfg(cfg.map),
        .hit_valid_o(hit_valid), .hit_lane_o(hit_lane)
    );

    window_timer u_timer (
        .detector, .arst_n_i, .load_i(timer_load), .run_i(timer_run),
        .cfg(cfg.timer), .window_end_o(window_end)
    );

    counter_ctrl u_ctrl (
        .detector, .arst_n_i, .cfg(cfg.ctrl), .window_end_i(window_end),
        .timer_load_o(timer_load), .timer_run_o(timer_run),
        .count_en_o(count_en), .clear_o(clear)
    );

    lane_counters #(.NUM_LANES(NUM_LANES), .COUNT_W(COUNT_W)) u_lanes (
        .detector, .arst_n_i, .hit_valid_i(hit_valid), .hit_lane_i(hit_lane),
        .count_en_i(count_en), .clear_i(clear), .window_end_i(window_end),
        .snap_o(snap), .snap_valid_o(count_valid_o)
    );

    counter_wb_regs #(.NUM_LANES(NUM_LANES), .COUNT_W(COUNT_W)) u_regs (
        .detector, .arst_n_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_dat_o, .wb_ack_o, .cfg(cfg.regs), .snap_i(snap)
    );

    // lane 0 in the low bits
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_flat
        assign count_data_o[l*COUNT_W +: COUNT_W] = snap[l];
    end

endmodule

`default_nettype wire

//--- tb_tag_counter.sv
// directed testbench for the windowed tag counter
//  wishbone read and write tasks, random tag driver
//  lookup-table mirror and per-lane count model
//  reset, registers, counting, mapping, window spacing and stop tests
`timescale 1ns/1ps
`default_nettype none

module tb_tag_counter;

    localparam int NUM_LANES = 4;
    localparam int COUNT_W   = 32;
    localparam int ADR_W     = counter_pkg::WB_ADR_W;
    localparam int DAT_W     = counter_pkg::WB_DAT_W;
    localparam int CHAN_W    = counter_pkg::CHAN_W;
    localparam int W_BASIC   = 200;                    // tests 3 and 4
    localparam int W_B2B     = 100;                    // tests 5 and 6
    localparam int B2B_RUNS  = 3;
    localparam int LIMIT     = 2 * W_BASIC + (B2B_RUNS + 1) * W_B2B + 2000;

    logic                         detector;
    logic                         arst_n_i;
    logic                         tag_valid_i;
    logic [CHAN_W-1:0]            tag_channel_i;
    logic                         wb_cyc_i;
    logic                         wb_stb_i;
    logic                         wb_we_i;
    logic [ADR_W-1:0]             wb_adr_i;
    logic [DAT_W-1:0]             wb_dat_i;
    wire  [DAT_W-1:0]             wb_dat_o;
    wire                          wb_ack_o;
    wire  [NUM_LANES*COUNT_W-1:0] count_data_o;
    wire                          count_valid_o;

    logic [counter_pkg::LANE_W-1:0] lut_model [2**CHAN_W]; // mirror of the table
    int unsigned                    exp_cnt [NUM_LANES];   // tags sent per lane
    logic [NUM_LANES*COUNT_W-1:0]   last_data;             // data at last valid pulse
    int                             last_cyc;
    int                             cycle = 0;
    int                             errors = 0;
    int                             checks = 0;
    int                             test_err = 0;
    int                             tests = 0;

    tag_counter_top #(.NUM_LANES(NUM_LANES), .COUNT_W(COUNT_W)) uut (.*);

    initial begin
        detector = 1'b0;
        forever #4 detector = ~detector;               // 8 ns period
    end

    // watchdog
    always @(posedge detector) begin
        cycle++;
        if (cycle >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////
    // checks
    task automatic record_error();
        errors++;
        test_err++;
    endtask

    task automatic check_count(input logic [COUNT_W-1:0] got, input logic [COUNT_W-1:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            record_error();
            $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [DAT_W-1:0] got, input logic [DAT_W-1:0] exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            record_error();
            $display("** Error at %0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            record_error();
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-10s %s (%0d errors)", name, (test_err == 0) ? "ok" : "FAIL", test_err);
        test_err = 0;
    endtask

    //////////////////////////////
    // wishbone classic master
    task automatic wb_cycle(input logic we, input logic [ADR_W-1:0] adr,
                            input logic [DAT_W-1:0] wdat, output logic [DAT_W-1:0] rdat);
        int waited;
        waited = 0;
        @(negedge detector);
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = wdat;
        @(negedge detector);
        while (!wb_ack_o && waited < 16) begin
            @(negedge detector);
            waited++;
        end
        if (!wb_ack_o) begin
            record_error();
            $display("wishbone slave gave no ack for address 0x%02h", adr);
        end
        rdat = wb_dat_o;                               // read data valid with ack
        @(negedge detector);                           // hold through the ack edge
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DAT_W-1:0] wdat);
        logic [DAT_W-1:0] unused;
        wb_cycle(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DAT_W-1:0] rdat);
        wb_cycle(1'b0, adr, '0, rdat);
    endtask

    //////////////////////////////
    // stream and model
    task automatic map_channel(input int ch, input logic [counter_pkg::LANE_W-1:0] lane);
        wb_write(counter_pkg::ADDR_LUT_BASE + ADR_W'(ch), DAT_W'(lane));
        lut_model[ch] = lane;
    endtask

    task automatic drive_tags(input int n_cycles, input int ch_lo, input int ch_hi);
        logic [counter_pkg::LANE_W-1:0] lane;
        for (int i = 0; i < n_cycles; i++) begin
            @(negedge detector);
            tag_valid_i   = ($urandom % 3) != 0;       // about two tags in three cycles
            tag_channel_i = CHAN_W'(ch_lo + $urandom % (ch_hi - ch_lo + 1));
            lane = lut_model[tag_channel_i];
            if (tag_valid_i && lane != counter_pkg::LANE_NONE && lane < NUM_LANES) begin
                exp_cnt[lane]++;
            end
        end
        @(negedge detector);
        tag_valid_i = 1'b0;
    endtask

    task automatic clear_model();
        for (int l = 0; l < NUM_LANES; l++) begin
            exp_cnt[l] = 0;
        end
    endtask

    task automatic wait_valid(input int max_cycles, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < max_cycles + 8) begin
            @(negedge detector);
            waited++;
            ok = count_valid_o;
        end
        if (ok) begin
            last_data = count_data_o;
            last_cyc  = cycle;
        end else begin
            record_error();
            $display("no count_valid_o pulse within %0d cycles", max_cycles + 8);
        end
    endtask

    task automatic check_lanes(input string what);
        for (int l = 0; l < NUM_LANES; l++) begin
            check_count(last_data[l*COUNT_W +: COUNT_W], COUNT_W'(exp_cnt[l]),
                        $sformatf("%s lane %0d", what, l));
        end
    endtask

    task automatic start_run(input int window);
        wb_write(counter_pkg::ADDR_WINDOW, DAT_W'(window));
        clear_model();
        wb_write(counter_pkg::ADDR_CTRL, 32'h1);
    endtask

    //////////////////////////////
    // test sequence
    initial begin
        logic             ok;
        logic [DAT_W-1:0] rd;
        int               prev_cyc;
        int               extra;
        void'($urandom(88649));
        arst_n_i      = 1'b0;
        tag_valid_i   = 1'b0;
        tag_channel_i = '0;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        for (int c = 0; c < 2**CHAN_W; c++) begin
            lut_model[c] = counter_pkg::LANE_NONE;     // reset value of the table
        end
        repeat (3) @(posedge detector);
        @(negedge detector);
        arst_n_i = 1'b1;

        check_flag(count_valid_o, 1'b0, "count_valid_o after reset");
        wb_read(counter_pkg::ADDR_WINDOW, rd);
        check_word(rd, 32'd1000, "window after reset");  // 1000 cycle default
        wb_read(counter_pkg::ADDR_STATUS, rd);
        check_word(rd, '0, "status after reset");
        end_test("reset");

        wb_write(counter_pkg::ADDR_WINDOW, 32'h0000_1234);
        wb_read(counter_pkg::ADDR_WINDOW, rd);
        check_word(rd, 32'h0000_1234, "window readback");
        for (int c = 1; c <= 4; c++) begin
            map_channel(c, counter_pkg::LANE_W'(c - 1)); // channels 1..4 onto lanes 0..3
        end
        for (int c = 1; c <= 5; c++) begin
            wb_read(counter_pkg::ADDR_LUT_BASE + ADR_W'(c), rd);
            check_word(rd, DAT_W'(lut_model[c]), $sformatf("table entry %0d", c));
        end
        end_test("registers");

        start_run(W_BASIC);
        repeat (20) @(negedge detector);
        drive_tags(120, 1, 4);
        wb_write(counter_pkg::ADDR_CTRL, 32'h2);       // this window is the last
        wait_valid(W_BASIC, ok);
        if (ok) begin
            check_lanes("basic");
        end
        end_test("counting");

        map_channel(5, 6'd1);                          // merges with channel 2
        map_channel(6, counter_pkg::LANE_NONE);
        start_run(W_BASIC);
        repeat (20) @(negedge detector);
        drive_tags(120, 0, 7);                         // 0, 6 and 7 are ignored
        wb_write(counter_pkg::ADDR_CTRL, 32'h2);
        wait_valid(W_BASIC, ok);
        if (ok) begin
            check_lanes("mapping");
        end
        end_test("mapping");

        start_run(W_B2B);
        prev_cyc = 0;
        for (int k = 0; k < B2B_RUNS; k++) begin
            repeat (10) @(negedge detector);
            drive_tags(50, 1, 7);
            wait_valid(W_B2B, ok);
            if (ok) begin
                check_lanes($sformatf("window %0d", k));
            end
            if (k > 0) begin
                check_word(DAT_W'(last_cyc - prev_cyc), DAT_W'(W_B2B), "valid spacing");
            end
            prev_cyc = last_cyc;
            clear_model();
        end
        end_test("windows");

        repeat (10) @(negedge detector);               // run still going from above
        drive_tags(40, 1, 7);
        wb_write(counter_pkg::ADDR_CTRL, 32'h2);
        wait_valid(W_B2B, ok);
        if (ok) begin
            check_lanes("final");
        end
        extra = 0;
        repeat (2 * W_B2B) begin
            @(negedge detector);
            if (count_valid_o) begin
                extra++;
            end
        end
        check_word(DAT_W'(extra), '0, "snapshots after stop");
        wb_read(counter_pkg::ADDR_STATUS, rd);
        check_flag(rd[0], 1'b0, "running bit");
        check_flag(rd[1], 1'b1, "snapshot bit");
        for (int l = 0; l < NUM_LANES; l++) begin
            wb_read(counter_pkg::ADDR_COUNT_BASE + ADR_W'(l), rd);
            check_count(rd[COUNT_W-1:0], last_data[l*COUNT_W +: COUNT_W],
                        $sformatf("bus count lane %0d", l));
        end
        end_test("stop");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
counter_pkg.sv
counter_cfg_if.sv
channel_map.sv
window_timer.sv
counter_ctrl.sv
lane_counters.sv
counter_wb_regs.sv
tag_counter_top.sv
tb_tag_counter.sv

//--- run_sim.sh
#!/bin/sh
# build and run the tag counter testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module tb_tag_counter
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_tag_counter)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
